/* replay_pkg.sv */
/*
 * Shared definitions for the packet capture and replay engine
 * Stream widths, stored beat layout and source-port mapping
 */
package replay_pkg;

  // Stream widths
  localparam int DATA_W  = 32;
  localparam int STRB_W  = DATA_W / 8;
  localparam int TUSER_W = 16;

  // One stored word is {last, strb, data}
  localparam int BEAT_W = DATA_W + STRB_W + 1;

  // Four replay queues, one per MAC port
  localparam int NUM_QUEUES = 4;
  localparam int QID_W      = $clog2(NUM_QUEUES);

  // One-hot source port in tuser, MAC ports sit on the even bits
  localparam int SRC_PORT_POS = 0;
  localparam int PORT_STRIDE  = 2;

  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [STRB_W-1:0]  strb_t;
  typedef logic [TUSER_W-1:0] tuser_t;
  typedef logic [QID_W-1:0]   qid_t;
  typedef logic [BEAT_W-1:0]  beat_t;

endpackage

/* capture_classifier.sv */
/*
 * Input stage of the capture path
 * Registers stream beats and maps each packet to a queue
 */
module capture_classifier (
  input  logic               axi_aclk,
  input  logic               reset,
  input  logic               sw_rst,
  input  replay_pkg::data_t  s_axis_tdata,
  input  replay_pkg::strb_t  s_axis_tstrb,
  input  replay_pkg::tuser_t s_axis_tuser,
  input  logic               s_axis_tvalid,
  output logic               s_axis_tready,
  input  logic               s_axis_tlast,
  output logic               cls_valid,
  input  logic               cls_ready,
  output replay_pkg::beat_t  cls_beat,
  output replay_pkg::qid_t   cls_qid,
  output logic               cls_drop
);

  logic              in_pkt;
  logic              take;
  logic [2:0]        hit_cnt;
  replay_pkg::qid_t  dec_qid;
  logic              dec_drop;
  replay_pkg::qid_t  pkt_qid;
  logic              pkt_drop;

  assign s_axis_tready = !cls_valid || cls_ready;
  assign take          = s_axis_tvalid && s_axis_tready;

  // Decode the MAC port bits, exactly one must be set
  always_comb begin
    hit_cnt = '0;
    dec_qid = '0;
    for (int q = 0; q < replay_pkg::NUM_QUEUES; q++) begin
      if (s_axis_tuser[replay_pkg::SRC_PORT_POS + replay_pkg::PORT_STRIDE * q]) begin
        hit_cnt = hit_cnt + 3'd1;
        dec_qid = replay_pkg::qid_t'(q);
      end
    end
    dec_drop = (hit_cnt != 3'd1);
  end

  always_ff @(posedge axi_aclk) begin
    if (reset || sw_rst) begin
      cls_valid <= 1'b0;
      in_pkt    <= 1'b0;
    end else begin
      if (take) begin
        cls_valid <= 1'b1;
        in_pkt    <= !s_axis_tlast;
      end else if (cls_ready) begin
        cls_valid <= 1'b0;
      end
    end
  end

  // Queue and drop flag are fixed by the first beat of a packet
  always_ff @(posedge axi_aclk) begin
    if (take) begin
      cls_beat <= {s_axis_tlast, s_axis_tstrb, s_axis_tdata};
      cls_qid  <= in_pkt ? pkt_qid : dec_qid;
      cls_drop <= in_pkt ? pkt_drop : dec_drop;
      if (!in_pkt) begin
        pkt_qid  <= dec_qid;
        pkt_drop <= dec_drop;
      end
    end
  end

  a_cls_hold : assert property (@(posedge axi_aclk) disable iff (reset || sw_rst)
    cls_valid && !cls_ready |=> cls_valid && $stable(cls_beat));

endmodule

/* capture_writer.sv */
/*
 * Capture writer
 * Per-queue write and committed pointers, whole-packet storage
 * with rollback when a packet overflows its window
 */
module capture_writer #(
  parameter int MEM_ADDR_WIDTH = 8
) (
  input  logic                       axi_aclk,
  input  logic                       reset,
  input  logic                       sw_rst,
  input  logic                       cls_valid,
  output logic                       cls_ready,
  input  replay_pkg::beat_t          cls_beat,
  input  replay_pkg::qid_t           cls_qid,
  input  logic                       cls_drop,
  input  logic [replay_pkg::NUM_QUEUES-1:0] enable_q,
  input  logic [replay_pkg::NUM_QUEUES-1:0][MEM_ADDR_WIDTH-1:0] mem_ad_low_q,
  input  logic [replay_pkg::NUM_QUEUES-1:0][MEM_ADDR_WIDTH-1:0] mem_ad_high_q,
  output logic                       wr_en,
  output logic [MEM_ADDR_WIDTH-1:0]  wr_addr,
  output replay_pkg::beat_t          wr_beat,
  output logic [replay_pkg::NUM_QUEUES-1:0][MEM_ADDR_WIDTH-1:0] fill_ptr
);

  logic [replay_pkg::NUM_QUEUES-1:0][MEM_ADDR_WIDTH-1:0] wr_ptr;
  logic [replay_pkg::NUM_QUEUES-1:0][MEM_ADDR_WIDTH-1:0] commit_ptr;

  logic              w_first;
  logic              w_skip;
  logic              beat_last;
  logic              beat_skip;
  logic              beat_over;
  logic              beat_store;
  replay_pkg::qid_t  wr_qid;

  // Never stalls the classifier
  assign cls_ready = 1'b1;
  assign fill_ptr  = commit_ptr;
  assign beat_last = cls_beat[replay_pkg::BEAT_W-1];

  always_comb begin
    beat_skip  = w_first ? (cls_drop || enable_q[cls_qid]) : w_skip;
    beat_over  = wr_ptr[cls_qid] > mem_ad_high_q[cls_qid];
    beat_store = cls_valid && !beat_skip && !beat_over;
  end

  always_ff @(posedge axi_aclk) begin
    if (reset || sw_rst) begin
      wr_en      <= 1'b0;
      w_first    <= 1'b1;
      w_skip     <= 1'b0;
      wr_ptr     <= mem_ad_low_q;
      commit_ptr <= mem_ad_low_q;
    end else begin
      wr_en <= beat_store;
      if (cls_valid) begin
        w_first <= beat_last;
        w_skip  <= beat_skip || beat_over;
        if (beat_store) begin
          wr_ptr[cls_qid] <= wr_ptr[cls_qid] + 1'b1;
          if (beat_last) begin
            commit_ptr[cls_qid] <= wr_ptr[cls_qid] + 1'b1;
          end
        end else if (beat_over && !beat_skip) begin
          // Packet does not fit, forget the part already written
          wr_ptr[cls_qid] <= commit_ptr[cls_qid];
        end
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (beat_store) begin
      wr_addr <= wr_ptr[cls_qid];
      wr_beat <= cls_beat;
      wr_qid  <= cls_qid;
    end
  end

  a_wr_in_window : assert property (@(posedge axi_aclk) disable iff (reset || sw_rst)
    wr_en |-> (wr_addr >= mem_ad_low_q[wr_qid]) && (wr_addr <= mem_ad_high_q[wr_qid]));

endmodule

/* packet_memory.sv */
/*
 * Packet memory
 * Synchronous RAM of stored beats, one write port and one read port
 */
module packet_memory #(
  parameter int MEM_ADDR_WIDTH = 8
) (
  input  logic                      axi_aclk,
  input  logic                      wr_en,
  input  logic [MEM_ADDR_WIDTH-1:0] wr_addr,
  input  replay_pkg::beat_t         wr_beat,
  input  logic                      rd_en,
  input  logic [MEM_ADDR_WIDTH-1:0] rd_addr,
  output replay_pkg::beat_t         rd_beat,
  output logic                      rd_beat_valid
);

  localparam int DEPTH = 2 ** MEM_ADDR_WIDTH;

  replay_pkg::beat_t mem [DEPTH];

  always_ff @(posedge axi_aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_beat;
    end
  end

  // Read data one cycle after the request
  always_ff @(posedge axi_aclk) begin
    rd_beat_valid <= rd_en;
    if (rd_en) begin
      rd_beat <= mem[rd_addr];
    end
  end

endmodule

/* replay_reader.sv */
/*
 * Replay reader
 * Picks the lowest enabled queue not yet done and walks its stored
 * region once per programmed pass
 */
module replay_reader #(
  parameter int MEM_ADDR_WIDTH     = 8,
  parameter int REPLAY_COUNT_WIDTH = 8
) (
  input  logic                      axi_aclk,
  input  logic                      reset,
  input  logic                      sw_rst,
  input  logic [replay_pkg::NUM_QUEUES-1:0] enable_q,
  input  logic [replay_pkg::NUM_QUEUES-1:0][MEM_ADDR_WIDTH-1:0] mem_ad_low_q,
  input  logic [replay_pkg::NUM_QUEUES-1:0][REPLAY_COUNT_WIDTH-1:0] replay_count_q,
  input  logic [replay_pkg::NUM_QUEUES-1:0][MEM_ADDR_WIDTH-1:0] fill_ptr,
  output logic                      rd_valid,
  input  logic                      rd_ready,
  output logic [MEM_ADDR_WIDTH-1:0] rd_addr,
  output replay_pkg::qid_t          rd_qid
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SELECT,
    ST_READ,
    ST_NEXT_PASS
  } state_t;

  state_t                            state;
  logic [replay_pkg::NUM_QUEUES-1:0] done_q;
  logic                              cand_found;
  replay_pkg::qid_t                  cand_q;
  replay_pkg::qid_t                  cur_q;
  logic [MEM_ADDR_WIDTH-1:0]         last_addr;
  logic [REPLAY_COUNT_WIDTH-1:0]     pass_left;
  logic                              region_empty;

  assign rd_valid     = (state == ST_READ);
  assign rd_qid       = cur_q;
  assign region_empty = fill_ptr[cur_q] == mem_ad_low_q[cur_q];

  // Lowest queue number wins
  always_comb begin
    cand_found = 1'b0;
    cand_q     = '0;
    for (int q = replay_pkg::NUM_QUEUES - 1; q >= 0; q--) begin
      if (enable_q[q] && !done_q[q]) begin
        cand_found = 1'b1;
        cand_q     = replay_pkg::qid_t'(q);
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (reset || sw_rst) begin
      state  <= ST_IDLE;
      done_q <= '0;
    end else begin
      // Disabling a queue re-arms it
      done_q <= done_q & enable_q;
      case (state)
        ST_IDLE: begin
          if (cand_found) begin
            state <= ST_SELECT;
          end
        end
        ST_SELECT: begin
          if (replay_count_q[cur_q] == '0 || region_empty) begin
            done_q[cur_q] <= 1'b1;
            state         <= ST_IDLE;
          end else begin
            state <= ST_READ;
          end
        end
        ST_READ: begin
          if (rd_ready && rd_addr == last_addr) begin
            state <= ST_NEXT_PASS;
          end
        end
        ST_NEXT_PASS: begin
          if (pass_left == REPLAY_COUNT_WIDTH'(1)) begin
            done_q[cur_q] <= 1'b1;
            state         <= ST_IDLE;
          end else if (!enable_q[cur_q]) begin
            state <= ST_IDLE;
          end else begin
            state <= ST_READ;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Queue, address and pass counters
  always_ff @(posedge axi_aclk) begin
    case (state)
      ST_IDLE: cur_q <= cand_q;
      ST_SELECT: begin
        rd_addr   <= mem_ad_low_q[cur_q];
        last_addr <= fill_ptr[cur_q] - 1'b1;
        pass_left <= replay_count_q[cur_q];
      end
      ST_READ: begin
        if (rd_ready) begin
          rd_addr <= rd_addr + 1'b1;
        end
      end
      ST_NEXT_PASS: begin
        rd_addr   <= mem_ad_low_q[cur_q];
        pass_left <= pass_left - 1'b1;
      end
      default: ;
    endcase
  end

  a_idle_quiet : assert property (@(posedge axi_aclk) disable iff (reset || sw_rst)
    state == ST_IDLE |-> !rd_valid);

endmodule

/* replay_streamer.sv */
/*
 * Replay streamer
 * Tracks reads in flight, buffers returned beats with their queue
 * and drives the output stream under back-pressure
 */
module replay_streamer #(
  parameter int OUT_FIFO_DEPTH = 4
) (
  input  logic               axi_aclk,
  input  logic               reset,
  input  logic               sw_rst,
  input  logic               rd_valid,
  output logic               rd_ready,
  input  replay_pkg::qid_t   rd_qid,
  input  replay_pkg::beat_t  rd_beat,
  input  logic               rd_beat_valid,
  output replay_pkg::data_t  m_axis_tdata,
  output replay_pkg::strb_t  m_axis_tstrb,
  output replay_pkg::tuser_t m_axis_tuser,
  output logic               m_axis_tvalid,
  input  logic               m_axis_tready,
  output logic               m_axis_tlast
);

  localparam int PTR_W = (OUT_FIFO_DEPTH > 1) ? $clog2(OUT_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(OUT_FIFO_DEPTH + 1);

  replay_pkg::beat_t fifo_beat [OUT_FIFO_DEPTH];
  replay_pkg::qid_t  fifo_qid  [OUT_FIFO_DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  fifo_cnt;
  logic [CNT_W-1:0]  inflight;
  replay_pkg::qid_t  ret_qid;
  replay_pkg::beat_t head_beat;
  replay_pkg::qid_t  head_qid;
  logic              issue;
  logic              push;
  logic              pop;

  // Reserve a slot for every read not yet returned
  assign rd_ready = (int'(fifo_cnt) + int'(inflight)) < OUT_FIFO_DEPTH;
  assign issue    = rd_valid && rd_ready;
  // Returns after a soft reset have no slot and are dropped
  assign push     = rd_beat_valid && (inflight != '0);
  assign pop      = m_axis_tvalid && m_axis_tready;

  always_ff @(posedge axi_aclk) begin
    if (reset || sw_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
      inflight <= '0;
    end else begin
      inflight <= inflight + CNT_W'(issue) - CNT_W'(push);
      fifo_cnt <= fifo_cnt + CNT_W'(push) - CNT_W'(pop);
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(OUT_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(OUT_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Memory latency is one cycle, so the queue of a return is the last issue's
  always_ff @(posedge axi_aclk) begin
    if (issue) begin
      ret_qid <= rd_qid;
    end
    if (push) begin
      fifo_beat[wr_ptr] <= rd_beat;
      fifo_qid[wr_ptr]  <= ret_qid;
    end
  end

  assign head_beat = fifo_beat[rd_ptr];
  assign head_qid  = fifo_qid[rd_ptr];

  assign m_axis_tvalid = (fifo_cnt != '0);
  assign m_axis_tdata  = head_beat[replay_pkg::DATA_W-1:0];
  assign m_axis_tstrb  = head_beat[replay_pkg::DATA_W +: replay_pkg::STRB_W];
  assign m_axis_tlast  = head_beat[replay_pkg::BEAT_W-1];
  // Only the replayed queue's port bit
  assign m_axis_tuser  = replay_pkg::tuser_t'(1) <<
                         (replay_pkg::SRC_PORT_POS + replay_pkg::PORT_STRIDE * int'(head_qid));

  a_no_overflow : assert property (@(posedge axi_aclk) disable iff (reset || sw_rst)
    push |-> (int'(fifo_cnt) < OUT_FIFO_DEPTH) || pop);

endmodule

/* pcap_replay_top.sv */
/*
 * Packet capture and replay engine, top level
 * Classifier, writer, packet memory, reader and streamer in a chain
 */
module pcap_replay_top #(
  parameter int MEM_ADDR_WIDTH     = 8,
  parameter int REPLAY_COUNT_WIDTH = 8,
  parameter int OUT_FIFO_DEPTH     = 4
) (
  input  logic               axi_aclk,
  input  logic               reset,

  input  replay_pkg::data_t  s_axis_tdata,
  input  replay_pkg::strb_t  s_axis_tstrb,
  input  replay_pkg::tuser_t s_axis_tuser,
  input  logic               s_axis_tvalid,
  output logic               s_axis_tready,
  input  logic               s_axis_tlast,

  output replay_pkg::data_t  m_axis_tdata,
  output replay_pkg::strb_t  m_axis_tstrb,
  output replay_pkg::tuser_t m_axis_tuser,
  output logic               m_axis_tvalid,
  input  logic               m_axis_tready,
  output logic               m_axis_tlast,

  input  logic [replay_pkg::NUM_QUEUES-1:0] enable_q,
  input  logic [replay_pkg::NUM_QUEUES-1:0][MEM_ADDR_WIDTH-1:0] mem_ad_low_q,
  input  logic [replay_pkg::NUM_QUEUES-1:0][MEM_ADDR_WIDTH-1:0] mem_ad_high_q,
  input  logic [replay_pkg::NUM_QUEUES-1:0][REPLAY_COUNT_WIDTH-1:0] replay_count_q,

  input  logic               sw_rst
);

  // Classifier to writer
  logic              cls_valid;
  logic              cls_ready;
  replay_pkg::beat_t cls_beat;
  replay_pkg::qid_t  cls_qid;
  logic              cls_drop;

  // Writer to memory
  logic                      wr_en;
  logic [MEM_ADDR_WIDTH-1:0] wr_addr;
  replay_pkg::beat_t         wr_beat;
  logic [replay_pkg::NUM_QUEUES-1:0][MEM_ADDR_WIDTH-1:0] fill_ptr;

  // Reader, memory and streamer
  logic                      rd_valid;
  logic                      rd_ready;
  logic                      rd_en;
  logic [MEM_ADDR_WIDTH-1:0] rd_addr;
  replay_pkg::qid_t          rd_qid;
  replay_pkg::beat_t         rd_beat;
  logic                      rd_beat_valid;

  assign rd_en = rd_valid && rd_ready;

  capture_classifier u_capture_classifier (
    .axi_aclk, .reset, .sw_rst,
    .s_axis_tdata, .s_axis_tstrb, .s_axis_tuser,
    .s_axis_tvalid, .s_axis_tready, .s_axis_tlast,
    .cls_valid, .cls_ready, .cls_beat, .cls_qid, .cls_drop
  );

  capture_writer #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_capture_writer (
    .axi_aclk, .reset, .sw_rst,
    .cls_valid, .cls_ready, .cls_beat, .cls_qid, .cls_drop,
    .enable_q, .mem_ad_low_q, .mem_ad_high_q,
    .wr_en, .wr_addr, .wr_beat, .fill_ptr
  );

  packet_memory #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_packet_memory (
    .axi_aclk,
    .wr_en, .wr_addr, .wr_beat,
    .rd_en, .rd_addr, .rd_beat, .rd_beat_valid
  );

  replay_reader #(
    .MEM_ADDR_WIDTH    (MEM_ADDR_WIDTH),
    .REPLAY_COUNT_WIDTH(REPLAY_COUNT_WIDTH)
  ) u_replay_reader (
    .axi_aclk, .reset, .sw_rst,
    .enable_q, .mem_ad_low_q, .replay_count_q, .fill_ptr,
    .rd_valid, .rd_ready, .rd_addr, .rd_qid
  );

  replay_streamer #(.OUT_FIFO_DEPTH(OUT_FIFO_DEPTH)) u_replay_streamer (
    .axi_aclk, .reset, .sw_rst,
    .rd_valid, .rd_ready, .rd_qid, .rd_beat, .rd_beat_valid,
    .m_axis_tdata, .m_axis_tstrb, .m_axis_tuser,
    .m_axis_tvalid, .m_axis_tready, .m_axis_tlast
  );

endmodule

/* replay_tb.sv */
/*
 * Directed testbench for the packet capture and replay engine
 * Reference queue model, output monitor, LFSR back-pressure and timeout
 */
module replay_tb;

  localparam int MEM_ADDR_WIDTH     = 8;
  localparam int REPLAY_COUNT_WIDTH = 8;
  localparam int OUT_FIFO_DEPTH     = 4;
  localparam logic [15:0] SEED      = 16'd34004;

  // Beats sent and beats expected over all tests
  localparam int IN_BEATS     = 55;
  localparam int OUT_BEATS    = 76;
  localparam int QUIET_CYCLES = 30;
  localparam int NUM_CHECKS   = 6;
  localparam int CYCLE_LIMIT  = 4 * (IN_BEATS + OUT_BEATS) + NUM_CHECKS * (2 * QUIET_CYCLES + 40);

  logic        axi_aclk;
  logic        reset;
  logic        sw_rst;
  logic [31:0] s_axis_tdata;
  logic [3:0]  s_axis_tstrb;
  logic [15:0] s_axis_tuser;
  logic        s_axis_tvalid;
  logic        s_axis_tready;
  logic        s_axis_tlast;
  logic [31:0] m_axis_tdata;
  logic [3:0]  m_axis_tstrb;
  logic [15:0] m_axis_tuser;
  logic        m_axis_tvalid;
  logic        m_axis_tready = 1'b1;
  logic        m_axis_tlast;
  logic [3:0]       enable_q;
  logic [3:0][7:0]  mem_ad_low_q;
  logic [3:0][7:0]  mem_ad_high_q;
  logic [3:0][7:0]  replay_count_q;

  logic [15:0] data_lfsr;
  logic [15:0] bp_lfsr = SEED;
  logic        bp_on;
  int          cycles = 0;
  int          checks;
  int          errors;

  // Model of stored words {last, strb, data} per queue
  logic [36:0] store_word [4][64];
  int          store_len [4];
  // Output beats as {user, last, strb, data}
  logic [52:0] exp_beat [$];
  logic [52:0] got_beat [$];

  pcap_replay_top #(
    .MEM_ADDR_WIDTH    (MEM_ADDR_WIDTH),
    .REPLAY_COUNT_WIDTH(REPLAY_COUNT_WIDTH),
    .OUT_FIFO_DEPTH    (OUT_FIFO_DEPTH)
  ) u_pcap_replay_top (
    .axi_aclk, .reset,
    .s_axis_tdata, .s_axis_tstrb, .s_axis_tuser,
    .s_axis_tvalid, .s_axis_tready, .s_axis_tlast,
    .m_axis_tdata, .m_axis_tstrb, .m_axis_tuser,
    .m_axis_tvalid, .m_axis_tready, .m_axis_tlast,
    .enable_q, .mem_ad_low_q, .mem_ad_high_q, .replay_count_q,
    .sw_rst
  );

  always #20 axi_aclk = ~axi_aclk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], data_lfsr[0]};
      data_lfsr = lfsr_next(data_lfsr);
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
  endtask

  // Random ready while back-pressure is on
  always @(negedge axi_aclk) begin
    if (bp_on) begin
      m_axis_tready = bp_lfsr[0];
      bp_lfsr = lfsr_next(bp_lfsr);
    end else begin
      m_axis_tready = 1'b1;
    end
  end

  always @(posedge axi_aclk) begin
    if (!reset && m_axis_tvalid && m_axis_tready) begin
      got_beat.push_back({m_axis_tuser, m_axis_tlast, m_axis_tstrb, m_axis_tdata});
    end
  end

  always @(posedge axi_aclk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // Sends one packet and applies the storage rules to the model
  task automatic send_packet(input logic [15:0] user, input int len);
    logic [36:0] words [64];
    logic [31:0] data;
    logic [31:0] strb;
    int          hits;
    int          q;
    hits = 0;
    q    = 0;
    for (int p = 0; p < 4; p++) begin
      if (user[2*p]) begin
        hits++;
        q = p;
      end
    end
    for (int i = 0; i < len; i++) begin
      rand_bits(32, data);
      rand_bits(4, strb);
      @(negedge axi_aclk);
      s_axis_tdata  = data;
      s_axis_tstrb  = strb[3:0];
      s_axis_tuser  = user;
      s_axis_tlast  = (i == len - 1);
      s_axis_tvalid = 1'b1;
      words[i] = {s_axis_tlast, strb[3:0], data};
      while (!s_axis_tready) @(negedge axi_aclk);
      @(posedge axi_aclk);
    end
    @(negedge axi_aclk);
    s_axis_tvalid = 1'b0;
    if (hits == 1 && !enable_q[q] &&
        store_len[q] + len <= int'(mem_ad_high_q[q]) - int'(mem_ad_low_q[q]) + 1) begin
      for (int i = 0; i < len; i++) begin
        store_word[q][store_len[q] + i] = words[i];
      end
      store_len[q] += len;
    end
  endtask

  task automatic add_replay(input int q, input int passes);
    for (int p = 0; p < passes; p++) begin
      for (int i = 0; i < store_len[q]; i++) begin
        exp_beat.push_back({16'h1 << (2 * q), store_word[q][i]});
      end
    end
  endtask

  task automatic check_output(input string name);
    int n;
    while (got_beat.size() < exp_beat.size()) @(negedge axi_aclk);
    repeat (QUIET_CYCLES) @(negedge axi_aclk);
    check_value({name, " beat count"}, 64'(exp_beat.size()), 64'(got_beat.size()));
    n = (got_beat.size() < exp_beat.size()) ? got_beat.size() : exp_beat.size();
    for (int i = 0; i < n; i++) begin
      check_value($sformatf("%s beat %0d data", name, i), exp_beat[i][31:0], got_beat[i][31:0]);
      check_value($sformatf("%s beat %0d strb", name, i), exp_beat[i][35:32],
                  got_beat[i][35:32]);
      check_value($sformatf("%s beat %0d last", name, i), exp_beat[i][36], got_beat[i][36]);
      check_value($sformatf("%s beat %0d user", name, i), exp_beat[i][52:37],
                  got_beat[i][52:37]);
    end
  endtask

  // Soft reset empties every queue
  task automatic clear_all();
    @(negedge axi_aclk);
    enable_q       = '0;
    replay_count_q = '0;
    repeat (2) @(negedge axi_aclk);
    sw_rst = 1'b1;
    repeat (2) @(negedge axi_aclk);
    sw_rst = 1'b0;
    for (int q = 0; q < 4; q++) begin
      store_len[q] = 0;
    end
    exp_beat.delete();
    got_beat.delete();
  endtask

  task automatic test_single_replay();
    clear_all();
    send_packet(16'h0001, 2);
    send_packet(16'h0001, 3);
    send_packet(16'h0001, 1);
    repeat (4) @(negedge axi_aclk);
    replay_count_q[0] = 8'd1;
    enable_q = 4'b0001;
    add_replay(0, 1);
    check_output("single replay");
  endtask

  task automatic test_repeated_replay();
    clear_all();
    send_packet(16'h0001, 2);
    send_packet(16'h0001, 2);
    send_packet(16'h0004, 3);
    send_packet(16'h0004, 1);
    send_packet(16'h0004, 2);
    repeat (4) @(negedge axi_aclk);
    // Queue 0 has a zero count and stays silent
    replay_count_q[0] = 8'd0;
    replay_count_q[1] = 8'd3;
    enable_q = 4'b0011;
    add_replay(0, 0);
    add_replay(1, 3);
    check_output("repeated replay");
  endtask

  task automatic test_dropped_input();
    clear_all();
    send_packet(16'h0040, 3);
    send_packet(16'h0002, 2);
    send_packet(16'h0011, 2);
    send_packet(16'h0040, 4);
    // Only one word is left in the window of queue 3
    send_packet(16'h0040, 3);
    send_packet(16'h0040, 1);
    replay_count_q[2] = 8'd1;
    enable_q = 4'b0100;
    repeat (3) @(negedge axi_aclk);
    send_packet(16'h0010, 2);
    repeat (4) @(negedge axi_aclk);
    enable_q = 4'b0000;
    repeat (3) @(negedge axi_aclk);
    replay_count_q[3] = 8'd1;
    enable_q = 4'b1100;
    add_replay(2, 1);
    add_replay(3, 1);
    check_output("dropped input");
  endtask

  task automatic test_back_pressure();
    clear_all();
    send_packet(16'h0010, 4);
    send_packet(16'h0010, 1);
    send_packet(16'h0010, 5);
    send_packet(16'h0010, 2);
    repeat (4) @(negedge axi_aclk);
    bp_on = 1'b1;
    replay_count_q[2] = 8'd2;
    enable_q = 4'b0100;
    add_replay(2, 2);
    check_output("back-pressure");
    bp_on = 1'b0;
  endtask

  task automatic test_queue_order_and_soft_reset();
    clear_all();
    send_packet(16'h0004, 2);
    send_packet(16'h0004, 3);
    send_packet(16'h0010, 1);
    send_packet(16'h0010, 4);
    repeat (4) @(negedge axi_aclk);
    replay_count_q[1] = 8'd2;
    replay_count_q[2] = 8'd2;
    enable_q = 4'b0110;
    add_replay(1, 2);
    add_replay(2, 2);
    check_output("queue order");
    clear_all();
    replay_count_q[1] = 8'd1;
    enable_q = 4'b0010;
    repeat (5) @(negedge axi_aclk);
    enable_q = 4'b0000;
    repeat (3) @(negedge axi_aclk);
    enable_q = 4'b0010;
    add_replay(1, 1);
    check_output("soft reset");
  endtask

  initial begin
    axi_aclk       = 1'b0;
    reset          = 1'b1;
    sw_rst         = 1'b0;
    s_axis_tdata   = '0;
    s_axis_tstrb   = '0;
    s_axis_tuser   = '0;
    s_axis_tvalid  = 1'b0;
    s_axis_tlast   = 1'b0;
    enable_q       = '0;
    replay_count_q = '0;
    mem_ad_low_q   = {8'hC0, 8'h80, 8'h40, 8'h00};
    mem_ad_high_q  = {8'hC7, 8'hBF, 8'h7F, 8'h3F};
    bp_on          = 1'b0;
    data_lfsr      = SEED;
    checks         = 0;
    errors         = 0;
    repeat (4) @(posedge axi_aclk);
    @(negedge axi_aclk);
    reset = 1'b0;
    @(negedge axi_aclk);
    check_value("reset s_axis_tready", 1, s_axis_tready);
    check_value("reset m_axis_tvalid", 0, m_axis_tvalid);
    test_single_replay();
    test_repeated_replay();
    test_dropped_input();
    test_back_pressure();
    test_queue_order_and_soft_reset();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* sim.f */
replay_pkg.sv
capture_classifier.sv
capture_writer.sv
packet_memory.sv
replay_reader.sv
replay_streamer.sv
pcap_replay_top.sv
replay_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the replay engine simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module replay_tb -o replay_sim

./obj_dir/replay_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0
